// ==== lce_pkg.sv ====
package lce_pkg;

  // cache geometry
  localparam int paddr_width_c  = 32;
  localparam int sets_c         = 16;
  localparam int assoc_c        = 4;
  localparam int block_width_c  = 128;

  localparam int lg_sets_c      = $clog2(sets_c);
  localparam int lg_assoc_c     = $clog2(assoc_c);
  localparam int block_offset_c = $clog2(block_width_c / 8);
  // address bits left over once index and byte offset are taken out
  localparam int tag_width_c    = paddr_width_c - lg_sets_c - block_offset_c;

  // lce and directory ids share one width
  localparam int id_width_c     = 4;

  // coherence state of a line, invalid must stay at zero
  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_m = 3'd3
  } coh_state_e;

  typedef enum logic [3:0] {
    e_cmd_sync,
    e_cmd_set_clear,
    e_cmd_inv,
    e_cmd_set_state,
    e_cmd_data,
    e_cmd_wb
  } lce_cmd_type_e;

  typedef enum logic [2:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_coh_ack,
    e_resp_wb,
    e_resp_null_wb
  } lce_resp_type_e;

  // memory opcodes
  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_state,
    e_tag_set_tag
  } tag_op_e;

  typedef enum logic [1:0] {
    e_stat_set_clear,
    e_stat_read,
    e_stat_clear_dirty
  } stat_op_e;

  typedef enum logic {
    e_data_read,
    e_data_write
  } data_op_e;

  // one command from a directory, header and block travel together
  typedef struct packed {
    lce_cmd_type_e              msg_type;
    logic [paddr_width_c-1:0]   addr;
    logic [id_width_c-1:0]      src_id;
    logic [lg_assoc_c-1:0]      way_id;
    coh_state_e                 state;
    logic [block_width_c-1:0]   data;
  } lce_cmd_s;

  typedef struct packed {
    lce_resp_type_e             msg_type;
    logic [paddr_width_c-1:0]   addr;
    logic [id_width_c-1:0]      src_id;
    logic [id_width_c-1:0]      dst_id;
    logic [block_width_c-1:0]   data;
  } lce_resp_s;

  typedef struct packed {
    tag_op_e                    opcode;
    logic [lg_sets_c-1:0]       index;
    logic [lg_assoc_c-1:0]      way_id;
    coh_state_e                 state;
    logic [tag_width_c-1:0]     tag;
  } tag_pkt_s;

  typedef struct packed {
    stat_op_e                   opcode;
    logic [lg_sets_c-1:0]       index;
    logic [lg_assoc_c-1:0]      way_id;
  } stat_pkt_s;

  typedef struct packed {
    data_op_e                   opcode;
    logic [lg_sets_c-1:0]       index;
    logic [lg_assoc_c-1:0]      way_id;
    logic [block_width_c-1:0]   data;
  } data_pkt_s;

  // stat memory read result, one dirty bit per way
  typedef struct packed {
    logic [assoc_c-1:0]         dirty;
  } stat_info_s;

endpackage

// ==== lce_read_buffer.sv ====
`timescale 1ns/1ns

module lce_read_buffer #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               read_accept_i,
  input  logic [width_p-1:0] data_i,
  output logic [width_p-1:0] data_o,
  output logic               valid_o
);

  logic read_en_r;
  logic valid_r;

  // read data shows up on data_i the cycle after the accept
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      read_en_r <= 1'b0;
      valid_r   <= 1'b0;
    end else begin
      read_en_r <= read_accept_i;
      // a new accept wins over a pending load
      valid_r   <= (valid_r | read_en_r) & ~read_accept_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_en_r) begin
      data_o <= data_i;
    end
  end

  assign valid_o = valid_r;

endmodule

// ==== lce_sweep_counter.sv ====
`timescale 1ns/1ns

module lce_sweep_counter
  import lce_pkg::*;
#(
  parameter int num_cce_p = 2
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 inc_i,
  input  logic                 clear_i,
  input  logic                 sync_ack_i,
  output logic [lg_sets_c-1:0] count_o,
  output logic                 sweep_last_o,
  output logic                 sync_last_o,
  output logic                 sync_done_o
);

  // wide enough for the set index and for the directory count
  localparam int cnt_width_lp = ((id_width_c > lg_sets_c) ? id_width_c : lg_sets_c) + 1;

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    final_sync;

  assign sweep_last_o = (cnt_r == cnt_width_lp'(sets_c - 1));
  assign sync_last_o  = (cnt_r == cnt_width_lp'(num_cce_p - 1));
  assign final_sync   = sync_ack_i & sync_last_o;
  assign count_o      = cnt_r[lg_sets_c-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i || final_sync) begin
      cnt_r <= '0;
    end else if (inc_i) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  // sticky once every directory has been acked
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_done_o <= 1'b0;
    end else if (final_sync) begin
      sync_done_o <= 1'b1;
    end
  end

endmodule

// ==== lce_cmd_fsm.sv ====
`timescale 1ns/1ns

module lce_cmd_fsm
  import lce_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [id_width_c-1:0] lce_id_i,
  input  lce_cmd_s              cmd_i,
  input  logic                  cmd_v_i,
  output logic                  cmd_ready_o,
  output lce_resp_s             resp_o,
  output logic                  resp_v_o,
  input  logic                  resp_ready_i,
  output tag_pkt_s              tag_pkt_o,
  output logic                  tag_v_o,
  input  logic                  tag_yumi_i,
  output stat_pkt_s             stat_pkt_o,
  output logic                  stat_v_o,
  input  logic                  stat_yumi_i,
  output data_pkt_s             data_pkt_o,
  output logic                  data_v_o,
  input  logic                  data_yumi_i,
  input  logic [lg_sets_c-1:0]  count_i,
  input  logic                  sweep_last_i,
  input  logic                  sync_last_i,
  input  stat_info_s            stat_buf_i,
  input  logic                  stat_buf_v_i,
  input  logic [block_width_c-1:0] data_buf_i,
  input  logic                  data_buf_v_i,
  output logic                  cnt_inc_o,
  output logic                  cnt_clear_o,
  output logic                  sync_ack_o,
  output logic                  stat_read_accept_o,
  output logic                  data_read_accept_o,
  output logic                  ready_o,
  output logic                  cache_req_complete_o
);

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_idle,
    e_coh_ack,
    e_wb_check,
    e_wb_dirty_read,
    e_wb_dirty_send
  } state_e;

  state_e state_r, state_n;

  logic [lg_sets_c-1:0]   cmd_index;
  logic [tag_width_c-1:0] cmd_tag;
  logic                   both_clear_yumi;

  assign cmd_index = cmd_i.addr[block_offset_c +: lg_sets_c];
  assign cmd_tag   = cmd_i.addr[paddr_width_c-1 -: tag_width_c];

  assign both_clear_yumi = tag_yumi_i & stat_yumi_i;

  // no commands until the sweep is over
  assign ready_o = (state_r != e_reset) && (state_r != e_clear);

  // reads that load the buffers a cycle later
  assign stat_read_accept_o = stat_yumi_i & (stat_pkt_o.opcode == e_stat_read);
  assign data_read_accept_o = data_yumi_i & (data_pkt_o.opcode == e_data_read);

  always_comb begin
    state_n              = state_r;
    cmd_ready_o          = 1'b0;
    resp_v_o             = 1'b0;
    tag_v_o              = 1'b0;
    stat_v_o             = 1'b0;
    data_v_o             = 1'b0;
    cnt_inc_o            = 1'b0;
    cnt_clear_o          = 1'b0;
    sync_ack_o           = 1'b0;
    cache_req_complete_o = 1'b0;

    // every response goes back to the directory that sent the command
    resp_o        = '0;
    resp_o.addr   = cmd_i.addr;
    resp_o.src_id = lce_id_i;
    resp_o.dst_id = cmd_i.src_id;

    tag_pkt_o         = '0;
    tag_pkt_o.index   = cmd_index;
    tag_pkt_o.way_id  = cmd_i.way_id;
    stat_pkt_o        = '0;
    stat_pkt_o.index  = cmd_index;
    stat_pkt_o.way_id = cmd_i.way_id;
    data_pkt_o        = '0;
    data_pkt_o.index  = cmd_index;
    data_pkt_o.way_id = cmd_i.way_id;

    unique case (state_r)
      e_reset: begin
        state_n = e_clear;
      end

      // wipe tag and stat of one set per accepted pair
      e_clear: begin
        tag_pkt_o.opcode  = e_tag_set_clear;
        tag_pkt_o.index   = count_i;
        tag_pkt_o.way_id  = '0;
        tag_pkt_o.state   = e_coh_i;
        tag_v_o           = 1'b1;
        stat_pkt_o.opcode = e_stat_set_clear;
        stat_pkt_o.index  = count_i;
        stat_pkt_o.way_id = '0;
        stat_v_o          = 1'b1;
        cnt_clear_o       = both_clear_yumi & sweep_last_i;
        cnt_inc_o         = both_clear_yumi & ~sweep_last_i;
        if (cnt_clear_o) begin
          state_n = e_idle;
        end
      end

      e_idle: begin
        if (cmd_v_i) begin
          case (cmd_i.msg_type)
            e_cmd_sync: begin
              resp_o.msg_type = e_resp_sync_ack;
              resp_v_o        = resp_ready_i;
              cmd_ready_o     = resp_v_o;
              sync_ack_o      = resp_v_o;
              // the counter clears itself on the last one
              cnt_inc_o       = resp_v_o & ~sync_last_i;
            end
            e_cmd_set_clear: begin
              tag_pkt_o.opcode  = e_tag_set_clear;
              tag_v_o           = 1'b1;
              stat_pkt_o.opcode = e_stat_set_clear;
              stat_v_o          = 1'b1;
              cmd_ready_o       = both_clear_yumi;
            end
            e_cmd_inv: begin
              tag_pkt_o.opcode = e_tag_set_state;
              tag_pkt_o.state  = e_coh_i;
              tag_v_o          = 1'b1;
              resp_o.msg_type  = e_resp_inv_ack;
              resp_v_o         = tag_yumi_i & resp_ready_i;
              cmd_ready_o      = resp_v_o;
            end
            e_cmd_set_state: begin
              tag_pkt_o.opcode = e_tag_set_state;
              tag_pkt_o.state  = cmd_i.state;
              tag_v_o          = 1'b1;
              cmd_ready_o      = tag_yumi_i;
            end
            e_cmd_data: begin
              tag_pkt_o.opcode  = e_tag_set_tag;
              tag_pkt_o.state   = cmd_i.state;
              tag_pkt_o.tag     = cmd_tag;
              tag_v_o           = 1'b1;
              data_pkt_o.opcode = e_data_write;
              data_pkt_o.data   = cmd_i.data;
              data_v_o          = 1'b1;
              if (tag_yumi_i && data_yumi_i) begin
                state_n = e_coh_ack;
              end
            end
            e_cmd_wb: begin
              stat_pkt_o.opcode = e_stat_read;
              stat_v_o          = 1'b1;
              if (stat_yumi_i) begin
                state_n = e_wb_check;
              end
            end
            // unknown types are dropped
            default: begin
              cmd_ready_o = 1'b1;
            end
          endcase
        end
      end

      // fill is in place, ack and wake the cache
      e_coh_ack: begin
        resp_o.msg_type      = e_resp_coh_ack;
        resp_v_o             = cmd_v_i & resp_ready_i;
        cmd_ready_o          = resp_v_o;
        cache_req_complete_o = resp_v_o;
        if (resp_v_o) begin
          state_n = e_idle;
        end
      end

      e_wb_check: begin
        if (stat_buf_v_i) begin
          if (stat_buf_i.dirty[cmd_i.way_id]) begin
            state_n = e_wb_dirty_read;
          end else begin
            resp_o.msg_type = e_resp_null_wb;
            resp_v_o        = resp_ready_i;
            cmd_ready_o     = resp_v_o;
            if (resp_v_o) begin
              state_n = e_idle;
            end
          end
        end
      end

      // read the block and mark it clean together
      e_wb_dirty_read: begin
        data_pkt_o.opcode = e_data_read;
        data_v_o          = 1'b1;
        stat_pkt_o.opcode = e_stat_clear_dirty;
        stat_v_o          = 1'b1;
        if (data_yumi_i && stat_yumi_i) begin
          state_n = e_wb_dirty_send;
        end
      end

      e_wb_dirty_send: begin
        resp_o.msg_type = e_resp_wb;
        resp_o.data     = data_buf_i;
        resp_v_o        = resp_ready_i & data_buf_v_i;
        cmd_ready_o     = resp_v_o;
        if (resp_v_o) begin
          state_n = e_idle;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// ==== lce_cmd_engine.sv ====
`timescale 1ns/1ns

module lce_cmd_engine
  import lce_pkg::*;
#(
  parameter int num_cce_p = 2
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [id_width_c-1:0]    lce_id_i,
  input  lce_cmd_s                 cmd_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,
  output lce_resp_s                resp_o,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i,
  output tag_pkt_s                 tag_pkt_o,
  output logic                     tag_v_o,
  input  logic                     tag_yumi_i,
  output stat_pkt_s                stat_pkt_o,
  output logic                     stat_v_o,
  input  logic                     stat_yumi_i,
  input  stat_info_s               stat_info_i,
  output data_pkt_s                data_pkt_o,
  output logic                     data_v_o,
  input  logic                     data_yumi_i,
  input  logic [block_width_c-1:0] data_i,
  output logic                     ready_o,
  output logic                     sync_done_o,
  output logic                     cache_req_complete_o
);

  logic [lg_sets_c-1:0]     count;
  logic                     sweep_last;
  logic                     sync_last;
  logic                     cnt_inc;
  logic                     cnt_clear;
  logic                     sync_ack;
  logic                     stat_read_accept;
  logic                     data_read_accept;
  stat_info_s               stat_buf;
  logic                     stat_buf_v;
  logic [block_width_c-1:0] data_buf;
  logic                     data_buf_v;

  lce_cmd_fsm fsm_i (
    .clk_i, .reset_i, .lce_id_i, .cmd_i, .cmd_v_i, .cmd_ready_o,
    .resp_o, .resp_v_o, .resp_ready_i,
    .tag_pkt_o, .tag_v_o, .tag_yumi_i,
    .stat_pkt_o, .stat_v_o, .stat_yumi_i,
    .data_pkt_o, .data_v_o, .data_yumi_i,
    .count_i(count), .sweep_last_i(sweep_last), .sync_last_i(sync_last),
    .stat_buf_i(stat_buf), .stat_buf_v_i(stat_buf_v),
    .data_buf_i(data_buf), .data_buf_v_i(data_buf_v),
    .cnt_inc_o(cnt_inc), .cnt_clear_o(cnt_clear), .sync_ack_o(sync_ack),
    .stat_read_accept_o(stat_read_accept), .data_read_accept_o(data_read_accept),
    .ready_o, .cache_req_complete_o
  );

  lce_sweep_counter #(.num_cce_p(num_cce_p)) counter_i (
    .clk_i, .reset_i, .inc_i(cnt_inc), .clear_i(cnt_clear), .sync_ack_i(sync_ack),
    .count_o(count), .sweep_last_o(sweep_last), .sync_last_o(sync_last), .sync_done_o
  );

  // dirty bits for the writeback decision
  lce_read_buffer #(.width_p($bits(stat_info_s))) stat_buf_i (
    .clk_i, .reset_i, .read_accept_i(stat_read_accept),
    .data_i(stat_info_i), .data_o(stat_buf), .valid_o(stat_buf_v)
  );

  // block being written back
  lce_read_buffer #(.width_p(block_width_c)) data_buf_i (
    .clk_i, .reset_i, .read_accept_i(data_read_accept),
    .data_i(data_i), .data_o(data_buf), .valid_o(data_buf_v)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_p       = 40,
  parameter int reset_cycles_p = 8
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // reset drops on a rising edge, like any other stimulus
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== tb_lce_cmd.sv ====
`timescale 1ns/1ns

module tb_lce_cmd
  import lce_pkg::*;
();

  localparam int                    num_cce_c   = 2;
  localparam logic [id_width_c-1:0] lce_id_c    = 4'h5;
  localparam logic [31:0]           seed_c      = 32'hbb0a_18cc;
  localparam int                    num_lines_c = 8;
  localparam int                    num_rand_c  = 24;
  localparam int                    num_cmds_c  = num_cce_c + 2 * num_lines_c + 3 + num_rand_c;
  // both sweep yumis together come about one cycle in four
  localparam int sweep_cycles_c   = sets_c * 40;
  localparam int timeout_cycles_c = 8 + sweep_cycles_c + num_cmds_c * 400;

  logic                     clk_i;
  logic                     reset_i;
  lce_cmd_s                 cmd_i;
  logic                     cmd_v_i;
  logic                     cmd_ready_o;
  lce_resp_s                resp_o;
  logic                     resp_v_o;
  logic                     resp_ready_i;
  tag_pkt_s                 tag_pkt_o;
  logic                     tag_v_o;
  logic                     tag_yumi_i;
  stat_pkt_s                stat_pkt_o;
  logic                     stat_v_o;
  logic                     stat_yumi_i;
  stat_info_s               stat_info_i;
  data_pkt_s                data_pkt_o;
  logic                     data_v_o;
  logic                     data_yumi_i;
  logic [block_width_c-1:0] data_i;
  logic                     ready_o;
  logic                     sync_done_o;
  logic                     cache_req_complete_o;

  // random grants that turn into yumi only while the packet is valid
  logic        tag_gnt;
  logic        stat_gnt;
  logic        data_gnt;
  logic [31:0] gnt_rng;
  logic [31:0] stim_rng;

  // cache memories
  logic [tag_width_c-1:0]   tag_mem   [sets_c][assoc_c];
  coh_state_e               state_mem [sets_c][assoc_c];
  logic [assoc_c-1:0]       dirty_mem [sets_c];
  logic [block_width_c-1:0] data_mem  [sets_c][assoc_c];

  logic [tag_width_c-1:0] line_tag [num_lines_c];
  lce_resp_s              exp_q [$];
  int                     errors     = 0;
  int                     checks     = 0;
  int                     sweep_cnt  = 0;
  bit                     ready_seen = 1'b0;

  tb_clock_gen #(.period_p(40), .reset_cycles_p(8)) clock_gen_i (
    .clk_o(clk_i), .reset_o(reset_i)
  );

  lce_cmd_engine #(.num_cce_p(num_cce_c)) lce_cmd_engine_i (
    .clk_i, .reset_i, .lce_id_i(lce_id_c), .cmd_i, .cmd_v_i, .cmd_ready_o,
    .resp_o, .resp_v_o, .resp_ready_i,
    .tag_pkt_o, .tag_v_o, .tag_yumi_i,
    .stat_pkt_o, .stat_v_o, .stat_yumi_i, .stat_info_i,
    .data_pkt_o, .data_v_o, .data_yumi_i, .data_i,
    .ready_o, .sync_done_o, .cache_req_complete_o
  );

  assign tag_yumi_i  = tag_v_o & tag_gnt;
  assign stat_yumi_i = stat_v_o & stat_gnt;
  assign data_yumi_i = data_v_o & data_gnt;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [block_width_c-1:0] rand_block();
    logic [block_width_c-1:0] b;
    for (int i = 0; i < block_width_c / 32; i++) begin
      b[i*32 +: 32] = next_rand();
    end
    return b;
  endfunction

  // each test line sits in its own set
  function automatic logic [lg_sets_c-1:0] line_index(input int l);
    return lg_sets_c'(2 * l);
  endfunction

  function automatic lce_cmd_s make_cmd(input lce_cmd_type_e kind, input int l,
                                        input coh_state_e st,
                                        input logic [block_width_c-1:0] d);
    lce_cmd_s    c;
    logic [31:0] r;
    r          = next_rand();
    c          = '0;
    c.msg_type = kind;
    c.addr     = {line_tag[l], line_index(l), r[block_offset_c-1:0]};
    c.src_id   = id_width_c'(l % num_cce_c);
    c.way_id   = lg_assoc_c'(l % assoc_c);
    c.state    = st;
    c.data     = d;
    return c;
  endfunction

  // expected response from the cache contents before the command runs
  function automatic bit ref_resp(input lce_cmd_s cmd, output lce_resp_s exp);
    logic [lg_sets_c-1:0] idx;
    idx        = cmd.addr[block_offset_c +: lg_sets_c];
    exp        = '0;
    exp.addr   = cmd.addr;
    exp.src_id = lce_id_c;
    exp.dst_id = cmd.src_id;
    ref_resp   = 1'b1;
    case (cmd.msg_type)
      e_cmd_sync: exp.msg_type = e_resp_sync_ack;
      e_cmd_inv:  exp.msg_type = e_resp_inv_ack;
      e_cmd_data: exp.msg_type = e_resp_coh_ack;
      e_cmd_wb: begin
        if (dirty_mem[idx][cmd.way_id]) begin
          exp.msg_type = e_resp_wb;
          exp.data     = data_mem[idx][cmd.way_id];
        end else begin
          exp.msg_type = e_resp_null_wb;
        end
      end
      default: ref_resp = 1'b0;
    endcase
  endfunction

  task automatic check_effect(input lce_cmd_s cmd);
    logic [lg_sets_c-1:0]   idx;
    logic [tag_width_c-1:0] tag;
    idx = cmd.addr[block_offset_c +: lg_sets_c];
    tag = cmd.addr[paddr_width_c-1 -: tag_width_c];
    checks++;
    case (cmd.msg_type)
      e_cmd_data: begin
        if (tag_mem[idx][cmd.way_id] !== tag || state_mem[idx][cmd.way_id] !== cmd.state
            || data_mem[idx][cmd.way_id] !== cmd.data) begin
          errors++;
          $display("MISMATCH @%0t: fill of set %0d way %0d not in the cache",
                   $time, idx, cmd.way_id);
        end
      end
      e_cmd_set_state: begin
        if (state_mem[idx][cmd.way_id] !== cmd.state) begin
          errors++;
          $display("MISMATCH @%0t: set %0d way %0d state %0d, expected %0d",
                   $time, idx, cmd.way_id, state_mem[idx][cmd.way_id], cmd.state);
        end
      end
      // invalidate ignores the state field of the command
      e_cmd_inv: begin
        if (state_mem[idx][cmd.way_id] !== e_coh_i) begin
          errors++;
          $display("MISMATCH @%0t: set %0d way %0d state %0d after invalidate",
                   $time, idx, cmd.way_id, state_mem[idx][cmd.way_id]);
        end
      end
      e_cmd_set_clear: begin
        for (int w = 0; w < assoc_c; w++) begin
          if (state_mem[idx][w] !== e_coh_i || dirty_mem[idx][w] !== 1'b0) begin
            errors++;
            $display("MISMATCH @%0t: set %0d way %0d not cleared", $time, idx, w);
          end
        end
      end
      e_cmd_wb: begin
        if (dirty_mem[idx][cmd.way_id] !== 1'b0) begin
          errors++;
          $display("MISMATCH @%0t: set %0d way %0d still dirty after writeback",
                   $time, idx, cmd.way_id);
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic send_cmd(input lce_cmd_s cmd);
    lce_resp_s exp;
    if (ref_resp(cmd, exp)) begin
      exp_q.push_back(exp);
    end
    cmd_i   <= cmd;
    cmd_v_i <= 1'b1;
    do begin
      @(posedge clk_i);
    end while (cmd_ready_o !== 1'b1);
    cmd_v_i <= 1'b0;
    // the cache model is quiet during one idle cycle
    @(posedge clk_i);
    check_effect(cmd);
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR @%0t: command type %0d finished without its response",
               $time, cmd.msg_type);
      exp_q.delete();
    end
  endtask

  always @(posedge clk_i) begin
    gnt_rng = xorshift32(gnt_rng);
    tag_gnt      <= gnt_rng[0];
    stat_gnt     <= gnt_rng[7];
    data_gnt     <= gnt_rng[13];
    resp_ready_i <= gnt_rng[21] | gnt_rng[22];
  end

  // cache model that returns read data the cycle after yumi
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (tag_v_o && tag_yumi_i) begin
        case (tag_pkt_o.opcode)
          e_tag_set_clear: begin
            for (int w = 0; w < assoc_c; w++) begin
              tag_mem[tag_pkt_o.index][w]   = '0;
              state_mem[tag_pkt_o.index][w] = e_coh_i;
            end
          end
          e_tag_set_state: state_mem[tag_pkt_o.index][tag_pkt_o.way_id] = tag_pkt_o.state;
          e_tag_set_tag: begin
            tag_mem[tag_pkt_o.index][tag_pkt_o.way_id]   = tag_pkt_o.tag;
            state_mem[tag_pkt_o.index][tag_pkt_o.way_id] = tag_pkt_o.state;
          end
          default: begin
          end
        endcase
      end
      if (stat_v_o && stat_yumi_i) begin
        case (stat_pkt_o.opcode)
          e_stat_set_clear:   dirty_mem[stat_pkt_o.index] = '0;
          e_stat_read:        stat_info_i.dirty <= dirty_mem[stat_pkt_o.index];
          e_stat_clear_dirty: dirty_mem[stat_pkt_o.index][stat_pkt_o.way_id] = 1'b0;
          default: begin
          end
        endcase
      end
      if (data_v_o && data_yumi_i) begin
        if (data_pkt_o.opcode == e_data_write) begin
          data_mem[data_pkt_o.index][data_pkt_o.way_id] = data_pkt_o.data;
        end else begin
          data_i <= data_mem[data_pkt_o.index][data_pkt_o.way_id];
        end
      end
    end
  end

  // compares responses, completions and the reset sweep
  always @(posedge clk_i) begin
    lce_resp_s exp;
    if (!reset_i) begin
      if (!ready_o && tag_v_o && stat_v_o && tag_yumi_i && stat_yumi_i) begin
        checks++;
        if (tag_pkt_o.index != sweep_cnt || stat_pkt_o.index != sweep_cnt
            || tag_pkt_o.opcode != e_tag_set_clear || stat_pkt_o.opcode != e_stat_set_clear) begin
          errors++;
          $display("MISMATCH @%0t: sweep cleared set %0d, expected %0d",
                   $time, tag_pkt_o.index, sweep_cnt);
        end
        sweep_cnt++;
      end
      if (ready_o && !ready_seen) begin
        ready_seen = 1'b1;
        checks++;
        if (sweep_cnt != sets_c) begin
          errors++;
          $display("MISMATCH @%0t: ready after %0d sets, expected %0d", $time, sweep_cnt, sets_c);
        end
      end
      if (resp_v_o && !resp_ready_i) begin
        errors++;
        $display("ERROR @%0t: response valid while the receiver is not ready", $time);
      end else if (resp_v_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR @%0t: response type %0d sent with none expected",
                   $time, resp_o.msg_type);
        end else begin
          exp = exp_q.pop_front();
          checks++;
          if (resp_o !== exp) begin
            errors++;
            $display("MISMATCH @%0t: resp type %0d addr %h dst %0d data %h, exp %0d %h %0d %h",
                     $time, resp_o.msg_type, resp_o.addr, resp_o.dst_id, resp_o.data,
                     exp.msg_type, exp.addr, exp.dst_id, exp.data);
          end
        end
      end
      if (cmd_v_i && cmd_ready_o) begin
        checks++;
        if (cache_req_complete_o !== (cmd_i.msg_type == e_cmd_data)) begin
          errors++;
          $display("MISMATCH @%0t: request complete %b for command type %0d",
                   $time, cache_req_complete_o, cmd_i.msg_type);
        end
      end else if (cache_req_complete_o) begin
        errors++;
        $display("ERROR @%0t: request complete pulsed outside a command end", $time);
      end
    end
  end

  initial begin
    repeat (timeout_cycles_c) @(posedge clk_i);
    $display("ERROR @%0t: run did not finish within %0d cycles", $time, timeout_cycles_c);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    lce_cmd_s                 cmd;
    logic [block_width_c-1:0] blk;
    logic [31:0]              r;
    int                       l;
    cmd_i        = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b0;
    tag_gnt      = 1'b0;
    stat_gnt     = 1'b0;
    data_gnt     = 1'b0;
    stat_info_i  = '0;
    data_i       = '0;
    gnt_rng      = seed_c;
    stim_rng     = ~seed_c;
    // junk everywhere so that the sweep has something to clear
    for (int s = 0; s < sets_c; s++) begin
      dirty_mem[s] = '1;
      for (int w = 0; w < assoc_c; w++) begin
        tag_mem[s][w]   = tag_width_c'(32'h00a5_5a00 ^ (s * assoc_c + w));
        state_mem[s][w] = coh_state_e'(1 + (s * assoc_c + w) % 3);
        data_mem[s][w]  = {4{32'hc0de_0000 | (s * assoc_c + w)}};
      end
    end
    for (int i = 0; i < num_lines_c; i++) begin
      line_tag[i] = '0;
    end

    while (reset_i !== 1'b0) @(posedge clk_i);
    checks++;
    if (tag_v_o || stat_v_o || data_v_o || resp_v_o || ready_o || cache_req_complete_o) begin
      errors++;
      $display("ERROR @%0t: outputs active in the first cycle after reset", $time);
    end
    while (ready_o !== 1'b1) @(posedge clk_i);
    for (int s = 0; s < sets_c; s++) begin
      for (int w = 0; w < assoc_c; w++) begin
        if (state_mem[s][w] !== e_coh_i || tag_mem[s][w] !== '0 || dirty_mem[s][w] !== 1'b0) begin
          errors++;
          $display("MISMATCH @%0t: set %0d way %0d not cleared by the sweep", $time, s, w);
        end
      end
    end

    for (int i = 0; i < num_cce_c; i++) begin
      checks++;
      if (sync_done_o !== 1'b0) begin
        errors++;
        $display("MISMATCH @%0t: sync done high before sync %0d", $time, i);
      end
      cmd        = make_cmd(e_cmd_sync, i, e_coh_i, '0);
      cmd.src_id = id_width_c'(i);
      send_cmd(cmd);
    end
    checks++;
    if (sync_done_o !== 1'b1) begin
      errors++;
      $display("MISMATCH @%0t: sync done low after the last sync", $time);
    end

    // fill every line and dirty every other one in the cache
    for (int i = 0; i < num_lines_c; i++) begin
      line_tag[i] = tag_width_c'(next_rand());
      blk         = rand_block();
      send_cmd(make_cmd(e_cmd_data, i, e_coh_e, blk));
      if (i % 2 == 0) begin
        dirty_mem[line_index(i)][i % assoc_c] = 1'b1;
      end
    end
    for (int i = 0; i < num_lines_c; i++) begin
      send_cmd(make_cmd(e_cmd_wb, i, e_coh_i, '0));
    end
    send_cmd(make_cmd(e_cmd_set_state, 1, e_coh_s, '0));
    send_cmd(make_cmd(e_cmd_inv, 2, e_coh_m, '0));
    send_cmd(make_cmd(e_cmd_set_clear, 3, e_coh_i, '0));

    for (int i = 0; i < num_rand_c; i++) begin
      r = next_rand();
      l = int'(r[2:0]);
      if (r[8]) begin
        dirty_mem[line_index(l)][l % assoc_c] = 1'b1;
      end
      case (r[5:4])
        2'd0: begin
          line_tag[l] = tag_width_c'(next_rand());
          blk         = rand_block();
          send_cmd(make_cmd(e_cmd_data, l, coh_state_e'(1 + r[12:11] % 3), blk));
        end
        2'd1: send_cmd(make_cmd(e_cmd_set_state, l, coh_state_e'(r[13:12]), '0));
        2'd2: send_cmd(make_cmd(e_cmd_inv, l, e_coh_m, '0));
        default: send_cmd(make_cmd(e_cmd_wb, l, e_coh_i, '0));
      endcase
    end

    @(posedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
lce_pkg.sv
lce_read_buffer.sv
lce_sweep_counter.sv
lce_cmd_fsm.sv
lce_cmd_engine.sv
tb_clock_gen.sv
tb_lce_cmd.sv

// ==== Bender.yml ====
package:
  name: lce_cmd_engine

sources:
  - lce_pkg.sv
  - lce_read_buffer.sv
  - lce_sweep_counter.sv
  - lce_cmd_fsm.sv
  - lce_cmd_engine.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_lce_cmd.sv
